//--- rtl/sh_core_macros.svh
`ifndef SH_CORE_MACROS_SVH
`define SH_CORE_MACROS_SVH

//******************************
// Datapath widths
//******************************

// Data and address
`define SH_WORD_W 32

// One instruction slot
`define SH_INSTR_W 16

// Sixteen general registers
`define SH_REG_IDX_W 4

//******************************
// Fixed values
//******************************
`define SH_NOP 16'h0009
`define SH_RESET_PC 32'h0000_0000

`endif

//--- rtl/sh_core_pkg.sv
`include "sh_core_macros.svh"

package sh_core_pkg;

	//******************************
	// Vector types
	//******************************
	typedef logic [`SH_WORD_W-1:0] word_t;
	typedef logic [`SH_INSTR_W-1:0] instr_t;
	typedef logic [`SH_REG_IDX_W-1:0] reg_idx_t;

	// Bit 3 is the lane at address offset 0
	typedef logic [3:0] byte_en_t;

	//******************************
	// Enumerations
	//******************************
	typedef enum logic [2:0] {
		PASS,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SHLL,
		SHLR
	} alu_op_e;

	// Same encoding as the size field of MOV.x
	typedef enum logic [1:0] {
		BYTE = 2'd0,
		WORD = 2'd1,
		LONG = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		MEM
	} core_state_e;

endpackage

//--- rtl/sh_dec_if.sv
`timescale 1ns/1ps

interface sh_dec_if;

	sh_core_pkg::reg_idx_t rn;
	sh_core_pkg::reg_idx_t rm;
	sh_core_pkg::word_t imm;
	logic use_imm;
	sh_core_pkg::alu_op_e alu_op;
	logic wr_rn;
	logic t_from_alu;
	logic t_to_rn;
	logic mem_rd;
	logic mem_wr;
	sh_core_pkg::mem_size_e mem_size;
	logic illegal;

	// Decoder side
	modport dec (
		output rn, rm, imm, use_imm, alu_op, wr_rn, t_from_alu, t_to_rn,
		output mem_rd, mem_wr, mem_size, illegal
	);

	// Execution control side
	modport exe (
		input rn, rm, imm, use_imm, alu_op, wr_rn, t_from_alu, t_to_rn,
		input mem_rd, mem_wr, mem_size, illegal
	);

endinterface

//--- rtl/sh_decoder.sv
`timescale 1ns/1ps
`include "sh_core_macros.svh"

module sh_decoder (
	input  sh_core_pkg::instr_t instr,
	sh_dec_if.dec               dec
);

	always_comb begin
		// Register fields sit at fixed positions
		dec.rn = instr[11:8];
		dec.rm = instr[7:4];
		dec.imm = {{(`SH_WORD_W-8){instr[7]}}, instr[7:0]};
		dec.use_imm = 1'b0;
		dec.alu_op = sh_core_pkg::PASS;
		dec.wr_rn = 1'b0;
		dec.t_from_alu = 1'b0;
		dec.t_to_rn = 1'b0;
		dec.mem_rd = 1'b0;
		dec.mem_wr = 1'b0;
		dec.mem_size = sh_core_pkg::LONG;
		dec.illegal = 1'b0;

		casez (instr)
			16'b1110_????_????_????: begin
				// MOV #imm,Rn
				dec.use_imm = 1'b1;
				dec.wr_rn = 1'b1;
			end
			16'b0111_????_????_????: begin
				dec.use_imm = 1'b1;
				dec.alu_op = sh_core_pkg::ADD;
				dec.wr_rn = 1'b1;
			end
			16'b0011_????_????_1100: begin
				dec.alu_op = sh_core_pkg::ADD;
				dec.wr_rn = 1'b1;
			end
			16'b0011_????_????_1000: begin
				dec.alu_op = sh_core_pkg::SUB;
				dec.wr_rn = 1'b1;
			end
			16'b0011_????_????_0000: dec.t_from_alu = 1'b1;
			16'b0010_????_????_1001: begin
				dec.alu_op = sh_core_pkg::AND;
				dec.wr_rn = 1'b1;
			end
			16'b0010_????_????_1011: begin
				dec.alu_op = sh_core_pkg::OR;
				dec.wr_rn = 1'b1;
			end
			16'b0010_????_????_1010: begin
				dec.alu_op = sh_core_pkg::XOR;
				dec.wr_rn = 1'b1;
			end
			16'b0100_????_0000_0000, 16'b0100_????_0000_0001: begin
				dec.alu_op = instr[0] ? sh_core_pkg::SHLR : sh_core_pkg::SHLL;
				dec.wr_rn = 1'b1;
				dec.t_from_alu = 1'b1;
			end
			16'b0000_????_0010_1001: begin
				dec.wr_rn = 1'b1;
				dec.t_to_rn = 1'b1;
			end
			16'b0010_????_????_0000, 16'b0010_????_????_0001, 16'b0010_????_????_0010: begin
				dec.mem_wr = 1'b1;
				dec.mem_size = sh_core_pkg::mem_size_e'(instr[1:0]);
			end
			16'b0110_????_????_0000, 16'b0110_????_????_0001, 16'b0110_????_????_0010: begin
				dec.mem_rd = 1'b1;
				dec.wr_rn = 1'b1;
				dec.mem_size = sh_core_pkg::mem_size_e'(instr[1:0]);
			end
			`SH_NOP: begin
			end
			default: dec.illegal = 1'b1;
		endcase
	end

endmodule

//--- rtl/sh_regfile.sv
`timescale 1ns/1ps
`include "sh_core_macros.svh"

module sh_regfile (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  sh_core_pkg::reg_idx_t ra,
	input  sh_core_pkg::reg_idx_t rb,
	output sh_core_pkg::word_t    qa,
	output sh_core_pkg::word_t    qb,
	input  sh_core_pkg::reg_idx_t wn,
	input  sh_core_pkg::word_t    wd,
	input  logic                  we
);

	sh_core_pkg::word_t regs [2**`SH_REG_IDX_W];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < 2**`SH_REG_IDX_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wn] <= wd;
		end
	end

	// Reads see the old value during a write
	assign qa = regs[ra];
	assign qb = regs[rb];

endmodule

//--- rtl/sh_alu.sv
`timescale 1ns/1ps

module sh_alu (
	input  sh_core_pkg::alu_op_e op,
	input  sh_core_pkg::word_t   a,
	input  sh_core_pkg::word_t   b,
	output sh_core_pkg::word_t   res,
	output logic                 t_out
);

	//******************************
	// Result
	//******************************
	always_comb begin
		case (op)
			sh_core_pkg::ADD:  res = a + b;
			sh_core_pkg::SUB:  res = a - b;
			sh_core_pkg::AND:  res = a & b;
			sh_core_pkg::OR:   res = a | b;
			sh_core_pkg::XOR:  res = a ^ b;
			sh_core_pkg::SHLL: res = {a[30:0], 1'b0};
			sh_core_pkg::SHLR: res = {1'b0, a[31:1]};
			default:           res = b;
		endcase
	end

	//******************************
	// T flag
	//******************************
	always_comb begin
		case (op)
			// Bit shifted out
			sh_core_pkg::SHLL: t_out = a[31];
			sh_core_pkg::SHLR: t_out = a[0];
			// CMP/EQ
			default:           t_out = (a == b);
		endcase
	end

endmodule

//--- rtl/sh_bus_lane.sv
`timescale 1ns/1ps

module sh_bus_lane (
	input  sh_core_pkg::word_t     addr,
	input  sh_core_pkg::mem_size_e size,
	input  sh_core_pkg::word_t     wdata,
	input  sh_core_pkg::word_t     rword,
	output sh_core_pkg::word_t     bus_do,
	output sh_core_pkg::byte_en_t  ba,
	output sh_core_pkg::word_t     rdata
);

	//******************************
	// Store side
	//******************************
	always_comb begin
		case (size)
			sh_core_pkg::BYTE: begin
				bus_do = {4{wdata[7:0]}};
				ba = 4'b1000 >> addr[1:0];
			end
			sh_core_pkg::WORD: begin
				bus_do = {2{wdata[15:0]}};
				ba = addr[1] ? 4'b0011 : 4'b1100;
			end
			default: begin
				bus_do = wdata;
				ba = 4'b1111;
			end
		endcase
	end

	//******************************
	// Load side
	//******************************
	always_comb begin
		logic [7:0] lane_b;
		logic [15:0] lane_h;

		// Big endian with offset 0 in the top byte
		lane_b = rword[8 * (3 - addr[1:0]) +: 8];
		lane_h = addr[1] ? rword[15:0] : rword[31:16];

		case (size)
			sh_core_pkg::BYTE: rdata = {{24{lane_b[7]}}, lane_b};
			sh_core_pkg::WORD: rdata = {{16{lane_h[15]}}, lane_h};
			default:           rdata = rword;
		endcase
	end

endmodule

//--- rtl/sh_core.sv
`timescale 1ns/1ps
`include "sh_core_macros.svh"

module sh_core (
	input  logic                  CLK,
	input  logic                  RST_N,
	output sh_core_pkg::word_t    bus_a,
	input  sh_core_pkg::word_t    bus_di,
	output sh_core_pkg::word_t    bus_do,
	output logic                  bus_wr,
	output sh_core_pkg::byte_en_t bus_ba,
	output logic                  bus_req,
	input  logic                  bus_wait,
	output logic                  ili
);

	sh_core_pkg::core_state_e state;
	sh_core_pkg::word_t pc;
	sh_core_pkg::instr_t ir;
	logic t_bit;

	sh_core_pkg::word_t rn_q;
	sh_core_pkg::word_t rm_q;
	sh_core_pkg::word_t rf_wd;
	logic rf_we;

	sh_core_pkg::word_t alu_b;
	sh_core_pkg::word_t alu_res;
	logic alu_t;

	sh_core_pkg::word_t mem_addr;
	sh_core_pkg::word_t ld_data;
	sh_core_pkg::byte_en_t lane_ba;

	sh_dec_if dec_bus ();

	sh_decoder decoder_i (
		.instr(ir),
		.dec  (dec_bus)
	);

	sh_regfile regfile_i (
		.CLK  (CLK),
		.RST_N(RST_N),
		.ra   (dec_bus.rn),
		.rb   (dec_bus.rm),
		.qa   (rn_q),
		.qb   (rm_q),
		.wn   (dec_bus.rn),
		.wd   (rf_wd),
		.we   (rf_we)
	);

	assign alu_b = dec_bus.use_imm ? dec_bus.imm : rm_q;

	sh_alu alu_i (
		.op   (dec_bus.alu_op),
		.a    (rn_q),
		.b    (alu_b),
		.res  (alu_res),
		.t_out(alu_t)
	);

	// Loads address through Rm, stores through Rn
	assign mem_addr = dec_bus.mem_rd ? rm_q : rn_q;

	sh_bus_lane bus_lane_i (
		.addr  (mem_addr),
		.size  (dec_bus.mem_size),
		.wdata (rm_q),
		.rword (bus_di),
		.bus_do(bus_do),
		.ba    (lane_ba),
		.rdata (ld_data)
	);

	//******************************
	// Execution FSM
	//******************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= sh_core_pkg::FETCH;
			pc <= `SH_RESET_PC;
			ir <= `SH_NOP;
			t_bit <= 1'b0;
		end else begin
			case (state)
				sh_core_pkg::FETCH: if (!bus_wait) begin
					ir <= pc[1] ? bus_di[15:0] : bus_di[31:16];
					state <= sh_core_pkg::EXEC;
				end
				sh_core_pkg::EXEC: begin
					pc <= pc + 32'd2;
					if (dec_bus.t_from_alu) t_bit <= alu_t;
					state <= (dec_bus.mem_rd || dec_bus.mem_wr) ? sh_core_pkg::MEM
						: sh_core_pkg::FETCH;
				end
				sh_core_pkg::MEM: if (!bus_wait) state <= sh_core_pkg::FETCH;
				default: state <= sh_core_pkg::FETCH;
			endcase
		end
	end

	// Writeback in EXEC, or at load completion
	assign rf_we = (state == sh_core_pkg::EXEC && dec_bus.wr_rn && !dec_bus.mem_rd) ||
		(state == sh_core_pkg::MEM && dec_bus.mem_rd && !bus_wait);
	assign rf_wd = dec_bus.mem_rd ? ld_data :
		dec_bus.t_to_rn ? {{(`SH_WORD_W-1){1'b0}}, t_bit} : alu_res;

	//******************************
	// Bus drive
	//******************************
	assign bus_req = (state != sh_core_pkg::EXEC);
	assign bus_a = (state == sh_core_pkg::MEM) ? mem_addr : pc;
	assign bus_wr = (state == sh_core_pkg::MEM) && dec_bus.mem_wr;
	assign bus_ba = (state == sh_core_pkg::MEM) ? lane_ba : 4'b1111;

	assign ili = (state == sh_core_pkg::EXEC) && dec_bus.illegal;

endmodule

//--- tb/sh_core_chk.sv
`timescale 1ns/1ps

module sh_core_chk (
	input logic                  CLK,
	input logic                  RST_N,
	input sh_core_pkg::word_t    bus_a,
	input sh_core_pkg::word_t    bus_do,
	input logic                  bus_wr,
	input sh_core_pkg::byte_en_t bus_ba,
	input logic                  bus_req,
	input logic                  bus_wait,
	input logic                  ili
);

	wr_needs_req: assert property (@(posedge CLK) disable iff (!RST_N)
		bus_wr |-> bus_req)
		else $error("bus_wr high without bus_req");

	// Single byte, either half, or all four lanes
	wr_lanes_legal: assert property (@(posedge CLK) disable iff (!RST_N)
		bus_wr |-> bus_ba inside {4'b1000, 4'b0100, 4'b0010, 4'b0001,
			4'b1100, 4'b0011, 4'b1111})
		else $error("illegal byte enables %b on a write", bus_ba);

	held_in_wait: assert property (@(posedge CLK) disable iff (!RST_N)
		bus_req && bus_wait |=> $stable(bus_a) && $stable(bus_do) &&
			$stable(bus_ba) && $stable(bus_wr))
		else $error("bus outputs changed during a wait cycle");

	ili_one_cycle: assert property (@(posedge CLK) disable iff (!RST_N)
		ili |=> !ili)
		else $error("ili high for two cycles");

endmodule

bind sh_core sh_core_chk chk_i (.*);

//--- tb/sh_core_tb.sv
`timescale 1ns/1ps
`include "sh_core_macros.svh"

module sh_core_tb;

	localparam int MEM_WORDS = 128;
	localparam int MAX_WAIT = 3;

	logic CLK;
	logic RST_N;
	sh_core_pkg::word_t bus_a;
	sh_core_pkg::word_t bus_di;
	sh_core_pkg::word_t bus_do;
	logic bus_wr;
	sh_core_pkg::byte_en_t bus_ba;
	logic bus_req;
	logic bus_wait;
	logic ili;

	sh_core_pkg::word_t mem [MEM_WORDS];
	sh_core_pkg::word_t ref_mem [MEM_WORDS];
	sh_core_pkg::word_t exp_a [$];
	sh_core_pkg::byte_en_t exp_ba [$];
	sh_core_pkg::word_t exp_d [$];
	int exp_ili;
	int exp_stores;
	int ili_n;
	int stores_n;
	int wait_run;
	integer seed = 32'hf041_7bc3;

	// Program from address 0 and data area at 0x100
	sh_core_pkg::instr_t prog [$] = '{
		// ALU results with base R8 = 0x100
		16'he105, 16'he2fd, 16'he370, 16'he840, 16'h4800, 16'h4800,
		16'h312c, 16'h71f0, 16'h2812, 16'h3328, 16'h2832,
		16'h2319, 16'h2832, 16'h232b, 16'h2832, 16'h231a, 16'h2832,
		// T flag through MOVT
		16'he405, 16'he505, 16'h3540, 16'h0629, 16'h2862, 16'h3510, 16'h0629, 16'h2862,
		16'h4200, 16'h0629, 16'h2862, 16'h2822, 16'h4201, 16'h0629, 16'h2862,
		16'h4201, 16'h0629, 16'h2862, 16'h2822,
		// Store lanes
		16'he900, 16'h398c, 16'h2910, 16'h7901, 16'h2910, 16'h7901, 16'h2910,
		16'h7901, 16'h2910, 16'h2811, 16'h79ff, 16'h2911, 16'h7902, 16'h2932,
		// Loads from 0x108 and 0x10c stored back
		16'hea08, 16'h3a8c, 16'h6ba0, 16'h28b2, 16'h7a01, 16'h6ba0, 16'h28b2,
		16'h7a01, 16'h6ba1, 16'h28b2, 16'h7afe, 16'h6ba1, 16'h28b2, 16'h6ba2, 16'h28b2,
		16'h7a04, 16'h6ba2, 16'h28b2, 16'h6ba1, 16'h28b2, 16'h7a03, 16'h6ba0, 16'h28b2,
		16'h6b82, 16'h29b2,
		// Illegal opcodes naming the registers stored next
		16'hfbff, 16'h0b00, 16'h28b2, 16'h4302, 16'h2832
	};

	sh_core dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic sh_core_pkg::instr_t prog_at(int k);
		return (k < prog.size()) ? prog[k] : `SH_NOP;
	endfunction

	function automatic sh_core_pkg::word_t lane_mask(sh_core_pkg::byte_en_t ba);
		return {{8{ba[3]}}, {8{ba[2]}}, {8{ba[1]}}, {8{ba[0]}}};
	endfunction

	function automatic sh_core_pkg::word_t merge_lanes(sh_core_pkg::word_t old,
		sh_core_pkg::word_t data, sh_core_pkg::byte_en_t ba);
		return (old & ~lane_mask(ba)) | (data & lane_mask(ba));
	endfunction

	task automatic load_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 32'ha5c3_0000 | 32'(i * 4);
		end
		// Two instructions per word with the first in the upper half
		for (int i = 0; i < 64; i++) begin
			mem[i] = {prog_at(2 * i), prog_at(2 * i + 1)};
		end
		mem[66] = 32'h807f_c33c;
		mem[67] = 32'h7ffe_0180;
		ref_mem = mem;
	endtask

	//******************************
	// Reference interpreter
	//******************************
	function automatic int run_reference();
		sh_core_pkg::word_t r [16];
		sh_core_pkg::word_t rn;
		sh_core_pkg::word_t rm;
		sh_core_pkg::word_t imm;
		sh_core_pkg::word_t w;
		sh_core_pkg::instr_t op;
		sh_core_pkg::reg_idx_t n;
		sh_core_pkg::reg_idx_t m;
		sh_core_pkg::byte_en_t ba;
		logic t;
		int ili_cnt;

		r = '{default: '0};
		t = 1'b0;
		ili_cnt = 0;
		for (int k = 0; k < prog.size(); k++) begin
			op = prog[k];
			n = op[11:8];
			m = op[7:4];
			rn = r[n];
			rm = r[m];
			imm = {{24{op[7]}}, op[7:0]};
			casez (op)
				16'b1110_????_????_????: r[n] = imm;
				16'b0111_????_????_????: r[n] = rn + imm;
				16'b0011_????_????_1100: r[n] = rn + rm;
				16'b0011_????_????_1000: r[n] = rn - rm;
				16'b0011_????_????_0000: t = (rn == rm);
				16'b0010_????_????_1001: r[n] = rn & rm;
				16'b0010_????_????_1011: r[n] = rn | rm;
				16'b0010_????_????_1010: r[n] = rn ^ rm;
				16'b0100_????_0000_0000: begin
					t = rn[31];
					r[n] = rn << 1;
				end
				16'b0100_????_0000_0001: begin
					t = rn[0];
					r[n] = rn >> 1;
				end
				16'b0000_????_0010_1001: r[n] = {31'b0, t};
				16'b0010_????_????_00??: begin
					if (op[1:0] == 2'b11) begin
						ili_cnt++;
					end else begin
						ba = 4'b0000;
						if (op[1:0] == 2'b00) begin
							ba[2'd3 - rn[1:0]] = 1'b1;
							w = {4{rm[7:0]}};
						end else if (op[1:0] == 2'b01) begin
							ba = rn[1] ? 4'b0011 : 4'b1100;
							w = {2{rm[15:0]}};
						end else begin
							ba = 4'b1111;
							w = rm;
						end
						exp_a.push_back(rn);
						exp_ba.push_back(ba);
						exp_d.push_back(w & lane_mask(ba));
						ref_mem[rn[8:2]] = merge_lanes(ref_mem[rn[8:2]], w, ba);
					end
				end
				16'b0110_????_????_00??: begin
					if (op[1:0] == 2'b11) begin
						ili_cnt++;
					end else begin
						w = ref_mem[rm[8:2]];
						// Addressed lane moved to the top, then sign-extended
						if (op[1:0] == 2'b00) begin
							w = w << (8 * rm[1:0]);
							w = {{24{w[31]}}, w[31:24]};
						end else if (op[1:0] == 2'b01) begin
							w = w << (16 * rm[1]);
							w = {{16{w[31]}}, w[31:16]};
						end
						r[n] = w;
					end
				end
				`SH_NOP: ;
				default: ili_cnt++;
			endcase
		end
		return ili_cnt;
	endfunction

	task automatic check(string what, sh_core_pkg::word_t got, sh_core_pkg::word_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	//******************************
	// Memory model
	//******************************
	always @(negedge CLK) begin : mem_model
		integer rnd;
		logic stall;

		rnd = $random(seed);
		stall = RST_N && bus_req && (rnd[1:0] == 2'b00) && (wait_run < MAX_WAIT);
		wait_run = stall ? wait_run + 1 : 0;
		bus_wait <= stall;
		bus_di <= mem[bus_a[8:2]];
		if (bus_req && bus_wr && !stall) begin
			mem[bus_a[8:2]] = merge_lanes(mem[bus_a[8:2]], bus_do, bus_ba);
		end
	end

	// Completed writes and ili pulses
	always @(posedge CLK) begin
		if (RST_N && bus_req && bus_wr && !bus_wait) begin
			if (exp_a.size() == 0) begin
				$display("A store to %h came after the last expected store", bus_a);
				$display("TB FAILED");
				$fatal(1);
			end
			check("store address", bus_a, exp_a.pop_front());
			check("byte enables", 32'(bus_ba), 32'(exp_ba.pop_front()));
			check("store data", bus_do & lane_mask(bus_ba), exp_d.pop_front());
			stores_n++;
		end
		if (RST_N && ili) ili_n++;
	end

	initial begin
		RST_N = 1'b0;
		bus_wait = 1'b0;
		bus_di = '0;
		ili_n = 0;
		stores_n = 0;
		wait_run = 0;
		load_memory();
		exp_ili = run_reference();
		exp_stores = exp_a.size();
		repeat (4) @(negedge CLK);
		RST_N <= 1'b1;
		wait (stores_n == exp_stores);
		repeat (4) @(negedge CLK);
		check("ili pulse count", 32'(ili_n), 32'(exp_ili));
		$display("TB PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (4 + prog.size() * 3 * (1 + MAX_WAIT) * 2) @(posedge CLK);
		$display("Watchdog expired before all expected stores were seen");
		$display("TB FAILED");
		$fatal(1);
	end

endmodule

//--- sim.f
+incdir+rtl
rtl/sh_core_pkg.sv
rtl/sh_dec_if.sv
rtl/sh_decoder.sv
rtl/sh_regfile.sv
rtl/sh_alu.sv
rtl/sh_bus_lane.sv
rtl/sh_core.sv
tb/sh_core_chk.sv
tb/sh_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= sh_core_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'TB PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
